// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_scc \
		-f files.f -Mdir obj_dir -o tb_scc_sim
	out="$$(./obj_dir/tb_scc_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: files.f
scc_pkg.sv
scc_scan_if.sv
scc_phase_decode.sv
scc_cmd_unit.sv
scc_scan_shifter.sv
scc_top.sv
scc_props.sv
tb_scc.sv

// File: scc_cmd_unit.sv
`timescale 1ns/100ps

module scc_cmd_unit
	import scc_pkg::*;
	#(
	parameter int NUM_GROUPS = 4,
	localparam int GROUP_W = $clog2(NUM_GROUPS)
	)
	(
	input  logic                     scc_clk,
	input  logic                     arst_n,
	input  logic                     cmd_valid,
	output logic                     cmd_ready,
	input  scc_op_t                  cmd_op,
	input  logic [GROUP_W-1:0]       cmd_group,
	input  logic [SETTING_WIDTH-1:0] cmd_setting,
	output logic [SETTING_WIDTH-1:0] dec_setting,
	input  phase_codes_t             dec_codes,
	scc_scan_if.source               scan
	);

	cmd_state_t               state_q;
	logic [SETTING_WIDTH-1:0] settings_q [NUM_GROUPS];
	phase_codes_t             req_codes_q;
	logic [GROUP_W-1:0]       req_group_q;
	logic                     cmd_fire;
	logic                     scan_fire;
	logic                     req_fire;

	assign cmd_fire  = cmd_valid && cmd_ready;
	assign scan_fire = cmd_fire && (cmd_op == OP_SCAN);
	assign req_fire  = scan.req_valid && scan.req_ready;

	// The request register is the only buffer, so a pending request blocks commands.
	assign cmd_ready = (state_q == CMD_IDLE);

	assign dec_setting = settings_q[cmd_group];

	always_ff @(posedge scc_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_GROUPS; i++)
				settings_q[i] <= '0;
		end
		else if (cmd_fire)
		begin
			case (cmd_op)
			OP_SET_PHASE :
				settings_q[cmd_group] <= cmd_setting;
			OP_CLEAR_ALL :
			begin
				for (int i = 0; i < NUM_GROUPS; i++)
					settings_q[i] <= '0;
			end
			default :
				; // Scans leave the settings alone.
			endcase
		end
	end

	always_ff @(posedge scc_clk or negedge arst_n)
	begin
		if (!arst_n)
			state_q <= CMD_IDLE;
		else
		begin
			case (state_q)
			CMD_IDLE :
				if (scan_fire)
					state_q <= CMD_PEND;
			CMD_PEND :
				if (req_fire)
					state_q <= CMD_IDLE;
			default :
				state_q <= CMD_IDLE;
			endcase
		end
	end

	// Codes are captured at acceptance, so a later set does not alter a queued scan.
	always_ff @(posedge scc_clk)
	begin
		if (scan_fire)
		begin
			req_codes_q <= dec_codes;
			req_group_q <= cmd_group;
		end
	end

	assign scan.req_valid = (state_q == CMD_PEND);
	assign scan.req_group = req_group_q;
	assign scan.req_codes = req_codes_q;

endmodule

// File: scc_phase_decode.sv
`timescale 1ns/100ps

module scc_phase_decode
	import scc_pkg::*;
	(
	input  logic [SETTING_WIDTH-1:0] setting,
	output phase_codes_t             codes
	);

	localparam phase_codes_t DEFAULT_CODES = '{
		dqsi_phase: 3'b010,
		dqs_phase:  7'b1110110,
		dq_phase:   7'b0110100,
		dqse_phase: 6'b000110
	};

	always_comb
	begin
		codes = DEFAULT_CODES; // dqsi_phase never moves off 2.
		case (setting)
		5'd0 :
			begin
				codes.dqs_phase  = 7'b0010110;
				codes.dq_phase   = 7'b1000110;
				codes.dqse_phase = 6'b000010;
			end
		5'd1 :
			begin
				codes.dqs_phase  = 7'b0110110;
				codes.dq_phase   = 7'b1100110;
				codes.dqse_phase = 6'b000011;
			end
		5'd2 :
			begin
				codes.dqs_phase  = 7'b1010110;
				codes.dq_phase   = 7'b0010110;
				codes.dqse_phase = 6'b000100;
			end
		5'd3 :
			begin
				codes.dqs_phase  = 7'b1110111;
				codes.dq_phase   = 7'b0110110;
				codes.dqse_phase = 6'b000101;
			end
		5'd4 :
			begin
				codes.dqs_phase  = 7'b0000111;
				codes.dq_phase   = 7'b1010110;
				codes.dqse_phase = 6'b000110;
			end
		5'd5 :
			begin
				codes.dqs_phase  = 7'b0100111;
				codes.dq_phase   = 7'b1110111;
				codes.dqse_phase = 6'b001111; // Not 7, the table really jumps here.
			end
		5'd6 :
			begin
				codes.dqs_phase  = 7'b1001000;
				codes.dq_phase   = 7'b0000111;
				codes.dqse_phase = 6'b001000;
			end
		5'd7 :
			begin
				codes.dqs_phase  = 7'b1101000;
				codes.dq_phase   = 7'b0100111;
				codes.dqse_phase = 6'b001001;
			end
		5'd8 :
			begin
				codes.dqs_phase  = 7'b0011000;
				codes.dq_phase   = 7'b1001000;
			end
		5'd9 :
			begin
				codes.dqs_phase  = 7'b0111000;
				codes.dq_phase   = 7'b1101000;
			end
		5'd10 :
			begin
				codes.dqs_phase  = 7'b1011000;
				codes.dq_phase   = 7'b0011000;
			end
		5'd11 :
			begin
				codes.dqs_phase  = 7'b1111001;
				codes.dq_phase   = 7'b0111000;
			end
		5'd12 :
			begin
				codes.dqs_phase  = 7'b0001001;
				codes.dq_phase   = 7'b1011000;
			end
		5'd13 :
			begin
				codes.dqs_phase  = 7'b0101001;
				codes.dq_phase   = 7'b1111001;
			end
		5'd14 :
			begin
				codes.dqs_phase  = 7'b1001010;
				codes.dq_phase   = 7'b0001001;
			end
		5'd15 :
			begin
				codes.dqs_phase  = 7'b1101010;
				codes.dq_phase   = 7'b0101001;
			end
		5'd16 :
			begin
				codes.dqs_phase  = 7'b0011010;
				codes.dq_phase   = 7'b1001010;
			end
		5'd17 :
			begin
				codes.dqs_phase  = 7'b0111010;
				codes.dq_phase   = 7'b1101010;
			end
		5'd18 :
			begin
				codes.dqs_phase  = 7'b1011010;
				codes.dq_phase   = 7'b0011010;
			end
		5'd19 :
			begin
				codes.dqs_phase  = 7'b1111011;
				codes.dq_phase   = 7'b0111010;
			end
		5'd20 :
			begin
				codes.dqs_phase  = 7'b0001011;
				codes.dq_phase   = 7'b1011010;
			end
		5'd21 :
			begin
				codes.dqs_phase  = 7'b0101011;
				codes.dq_phase   = 7'b1111011;
			end
		default :
			; // Out-of-range settings keep the default codes.
		endcase
	end

endmodule

// File: scc_pkg.sv
package scc_pkg;

	// Only the low 5 bits of a setting ever reach the decode table.
	localparam int SETTING_WIDTH = 5;

	// One frame carries all four phase codes of a DQS group.
	localparam int SCAN_LEN = 23;

	localparam int CNT_W = $clog2(SCAN_LEN);

	typedef enum logic [1:0]
	{
		OP_SET_PHASE = 2'd0, // Write one group's setting.
		OP_CLEAR_ALL = 2'd1, // Zero every group's setting.
		OP_SCAN      = 2'd2  // Shift one group's codes out.
	} scc_op_t;

	// Field order sets the scan order, so dqse_phase leaves first.
	typedef struct packed
	{
		logic [2:0] dqsi_phase;
		logic [6:0] dqs_phase;
		logic [6:0] dq_phase;
		logic [5:0] dqse_phase;
	} phase_codes_t;

	typedef enum logic
	{
		CMD_IDLE = 1'b0,
		CMD_PEND = 1'b1 // A scan request waits for the shifter.
	} cmd_state_t;

	typedef enum logic [1:0]
	{
		SH_IDLE   = 2'd0,
		SH_SHIFT  = 2'd1,
		SH_UPDATE = 2'd2
	} shift_state_t;

endpackage

// File: scc_props.sv
`timescale 1ns/100ps

module scc_props
	import scc_pkg::*;
	#(
	parameter int NUM_GROUPS = 4,
	localparam int GROUP_W = $clog2(NUM_GROUPS)
	)
	(
	input logic                     scc_clk,
	input logic                     arst_n,
	input logic                     cmd_valid,
	input logic                     cmd_ready,
	input scc_op_t                  cmd_op,
	input logic [GROUP_W-1:0]       cmd_group,
	input logic [SETTING_WIDTH-1:0] cmd_setting,
	input logic [NUM_GROUPS-1:0]    scan_enable,
	input logic [NUM_GROUPS-1:0]    scan_update
	);

	// A stalled command keeps its fields until it is taken.
	cmd_held: assert property (@(posedge scc_clk) disable iff (!arst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_group)
			&& $stable(cmd_setting))
		else $error("Command changed or dropped while cmd_ready was low.");

	// An accepted scan occupies the request register.
	scan_blocks: assert property (@(posedge scc_clk) disable iff (!arst_n)
		cmd_valid && cmd_ready && cmd_op == OP_SCAN |=> !cmd_ready)
		else $error("cmd_ready stayed high after a scan was accepted.");

	update_single: assert property (@(posedge scc_clk) disable iff (!arst_n)
		|scan_update |=> scan_update == '0)
		else $error("scan_update stayed high for more than one cycle.");

	update_after_frame: assert property (@(posedge scc_clk) disable iff (!arst_n)
		|scan_update |-> $past(scan_enable) == scan_update)
		else $error("scan_update did not follow the same group's enable.");

endmodule

bind scc_top scc_props #(.NUM_GROUPS(NUM_GROUPS)) u_props (
	.scc_clk     (scc_clk),
	.arst_n      (arst_n),
	.cmd_valid   (cmd_valid),
	.cmd_ready   (cmd_ready),
	.cmd_op      (cmd_op),
	.cmd_group   (cmd_group),
	.cmd_setting (cmd_setting),
	.scan_enable (scan_enable),
	.scan_update (scan_update)
);

// File: scc_scan_if.sv
`timescale 1ns/100ps

interface scc_scan_if
	import scc_pkg::*;
	#(
	parameter int NUM_GROUPS = 4,
	localparam int GROUP_W = $clog2(NUM_GROUPS)
	)
	();

	logic               req_valid;
	logic               req_ready;
	logic [GROUP_W-1:0] req_group;
	phase_codes_t       req_codes; // Already decoded, so the shifter only serializes.

	modport source
	(
		output req_valid,
		input  req_ready,
		output req_group,
		output req_codes
	);

	modport sink
	(
		input  req_valid,
		output req_ready,
		input  req_group,
		input  req_codes
	);

endinterface

// File: scc_scan_shifter.sv
`timescale 1ns/100ps

module scc_scan_shifter
	import scc_pkg::*;
	#(
	parameter int NUM_GROUPS = 4,
	localparam int GROUP_W = $clog2(NUM_GROUPS)
	)
	(
	input  logic                  scc_clk,
	input  logic                  arst_n,
	scc_scan_if.sink              scan,
	output logic                  scan_data,
	output logic [NUM_GROUPS-1:0] scan_enable,
	output logic [NUM_GROUPS-1:0] scan_update
	);

	shift_state_t          state_q;
	logic [CNT_W-1:0]      bit_cnt_q;
	logic [SCAN_LEN-1:0]   shift_q;
	logic [GROUP_W-1:0]    group_q;
	logic                  req_fire;
	logic                  last_bit;

	assign scan.req_ready = (state_q == SH_IDLE);
	assign req_fire       = scan.req_valid && scan.req_ready;
	assign last_bit       = (bit_cnt_q == CNT_W'(SCAN_LEN - 1));

	always_ff @(posedge scc_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q   <= SH_IDLE;
			bit_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
			SH_IDLE :
				if (req_fire)
				begin
					state_q   <= SH_SHIFT;
					bit_cnt_q <= '0;
				end
			SH_SHIFT :
			begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (last_bit)
					state_q <= SH_UPDATE;
			end
			SH_UPDATE :
				state_q <= SH_IDLE; // Update lasts exactly one cycle.
			default :
				state_q <= SH_IDLE;
			endcase
		end
	end

	always_ff @(posedge scc_clk)
	begin
		if (req_fire)
		begin
			shift_q <= scan.req_codes;
			group_q <= scan.req_group;
		end
		else if (state_q == SH_SHIFT)
			shift_q <= shift_q >> 1; // LSB first.
	end

	always_comb
	begin
		scan_enable = '0;
		scan_update = '0;
		if (state_q == SH_SHIFT)
			scan_enable[group_q] = 1'b1;
		if (state_q == SH_UPDATE)
			scan_update[group_q] = 1'b1;
	end

	// Held low between frames so the chain sees a quiet line.
	assign scan_data = (state_q == SH_SHIFT) && shift_q[0];

endmodule

// File: scc_top.sv
`timescale 1ns/100ps

module scc_top
	import scc_pkg::*;
	#(
	parameter int NUM_GROUPS = 4,
	localparam int GROUP_W = $clog2(NUM_GROUPS)
	)
	(
	input  logic                     scc_clk,
	input  logic                     arst_n,
	input  logic                     cmd_valid,
	output logic                     cmd_ready,
	input  scc_op_t                  cmd_op,
	input  logic [GROUP_W-1:0]       cmd_group,
	input  logic [SETTING_WIDTH-1:0] cmd_setting,
	output logic                     scan_data,
	output logic [NUM_GROUPS-1:0]    scan_enable,
	output logic [NUM_GROUPS-1:0]    scan_update
	);

	logic [SETTING_WIDTH-1:0] dec_setting;
	phase_codes_t             dec_codes;

	scc_scan_if #(.NUM_GROUPS(NUM_GROUPS)) scan_bus ();

	scc_cmd_unit #(.NUM_GROUPS(NUM_GROUPS)) u_cmd_unit (
		.scc_clk     (scc_clk),
		.arst_n      (arst_n),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_op      (cmd_op),
		.cmd_group   (cmd_group),
		.cmd_setting (cmd_setting),
		.dec_setting (dec_setting),
		.dec_codes   (dec_codes),
		.scan        (scan_bus.source)
	);

	scc_phase_decode u_phase_decode (
		.setting (dec_setting),
		.codes   (dec_codes)
	);

	scc_scan_shifter #(.NUM_GROUPS(NUM_GROUPS)) u_scan_shifter (
		.scc_clk     (scc_clk),
		.arst_n      (arst_n),
		.scan        (scan_bus.sink),
		.scan_data   (scan_data),
		.scan_enable (scan_enable),
		.scan_update (scan_update)
	);

endmodule

// File: tb_scc.sv
`timescale 1ns/100ps

module tb_scc
	import scc_pkg::*;
	();

	localparam int NUM_GROUPS = 4;
	localparam int GROUP_W = $clog2(NUM_GROUPS);
	localparam int RESET_CYCLES = 5;
	localparam int N_RAND = 24;
	localparam int N_BURST = 8;
	localparam int NUM_CMDS = 4 * NUM_GROUPS + 2 * N_RAND + 1 + N_BURST;

	// Expected phase table, indexed by setting.
	localparam logic [6:0] DQS_TAB [22] = '{
		7'b0010110, 7'b0110110, 7'b1010110, 7'b1110111, 7'b0000111, 7'b0100111,
		7'b1001000, 7'b1101000, 7'b0011000, 7'b0111000, 7'b1011000, 7'b1111001,
		7'b0001001, 7'b0101001, 7'b1001010, 7'b1101010, 7'b0011010, 7'b0111010,
		7'b1011010, 7'b1111011, 7'b0001011, 7'b0101011};
	localparam logic [6:0] DQ_TAB [22] = '{
		7'b1000110, 7'b1100110, 7'b0010110, 7'b0110110, 7'b1010110, 7'b1110111,
		7'b0000111, 7'b0100111, 7'b1001000, 7'b1101000, 7'b0011000, 7'b0111000,
		7'b1011000, 7'b1111001, 7'b0001001, 7'b0101001, 7'b1001010, 7'b1101010,
		7'b0011010, 7'b0111010, 7'b1011010, 7'b1111011};
	localparam logic [5:0] DQSE_TAB [8] = '{6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd15, 6'd8, 6'd9};

	logic                     scc_clk;
	logic                     arst_n;
	logic                     cmd_valid;
	logic                     cmd_ready;
	scc_op_t                  cmd_op;
	logic [GROUP_W-1:0]       cmd_group;
	logic [SETTING_WIDTH-1:0] cmd_setting;
	logic                     scan_data;
	logic [NUM_GROUPS-1:0]    scan_enable;
	logic [NUM_GROUPS-1:0]    scan_update;

	logic [SETTING_WIDTH-1:0] model_settings [NUM_GROUPS];
	logic [GROUP_W-1:0]       exp_groups [$];
	phase_codes_t             exp_codes [$];
	logic [31:0]              rng = 32'd56;
	int                       errors = 0;
	int                       frames_done = 0;
	int                       bit_count = 0;
	logic [GROUP_W-1:0]       frame_group;
	phase_codes_t             frame;
	logic                     saw_stall;

	scc_top #(.NUM_GROUPS(NUM_GROUPS)) uut (.*);

	initial
	begin
		scc_clk = 1'b0;
		forever #50 scc_clk = ~scc_clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic phase_codes_t model_codes(input logic [SETTING_WIDTH-1:0] s);
		phase_codes_t c;
		c.dqsi_phase = 3'd2;
		if (s <= 21)
		begin
			c.dqs_phase  = DQS_TAB[s];
			c.dq_phase   = DQ_TAB[s];
			c.dqse_phase = (s < 8) ? DQSE_TAB[s[2:0]] : 6'd6; // Upper half keeps its default.
		end
		else
		begin
			c.dqs_phase  = 7'b1110110;
			c.dq_phase   = 7'b0110100;
			c.dqse_phase = 6'd6;
		end
		return c;
	endfunction

	function automatic logic [GROUP_W-1:0] onehot_index(input logic [NUM_GROUPS-1:0] v);
		logic [GROUP_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < NUM_GROUPS; i++)
			if (v[i])
				idx = GROUP_W'(i);
		return idx;
	endfunction

	task automatic check_codes(input string name, input phase_codes_t exp, input phase_codes_t act);
		if (exp !== act)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_group(input string name, input logic [GROUP_W-1:0] exp,
		input logic [GROUP_W-1:0] act);
		if (exp !== act)
		begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance.
	task automatic send_cmd(input scc_op_t op, input logic [GROUP_W-1:0] grp,
		input logic [SETTING_WIDTH-1:0] set);
		cmd_valid   = 1'b1;
		cmd_op      = op;
		cmd_group   = grp;
		cmd_setting = set;
		if (!cmd_ready)
			saw_stall = 1'b1;
		while (!cmd_ready)
			@(negedge scc_clk);
		@(negedge scc_clk);
		cmd_valid = 1'b0;
		case (op)
		OP_SET_PHASE :
			model_settings[grp] = set;
		OP_CLEAR_ALL :
			for (int i = 0; i < NUM_GROUPS; i++)
				model_settings[i] = '0;
		default :
		begin
			exp_groups.push_back(grp);
			exp_codes.push_back(model_codes(model_settings[grp]));
		end
		endcase
	endtask

	// Outputs change on the rising edge, so the chain is sampled half a cycle later.
	always @(negedge scc_clk)
	begin
		if (arst_n)
		begin
			if (scan_enable != '0)
			begin
				check_bit("enable one-hot", 1'b1, $onehot(scan_enable));
				if (bit_count == 0)
					frame_group = onehot_index(scan_enable);
				else
					check_group("enable group", frame_group, onehot_index(scan_enable));
				frame = {scan_data, frame[SCAN_LEN-1:1]}; // Frame arrives LSB first.
				bit_count++;
			end
			if (scan_update != '0)
			begin
				check_bit("update one-hot", 1'b1, $onehot(scan_update));
				check_group("update group", frame_group, onehot_index(scan_update));
				if (bit_count != SCAN_LEN)
				begin
					$display("Frame for group %0d had %0d enable cycles instead of %0d.",
						frame_group, bit_count, SCAN_LEN);
					errors++;
				end
				if (exp_groups.size() == 0)
				begin
					$display("An update pulse came with no scan outstanding.");
					errors++;
				end
				else
				begin
					check_group("frame group", exp_groups.pop_front(), frame_group);
					check_codes("frame codes", exp_codes.pop_front(), frame);
				end
				bit_count = 0;
				frames_done++;
			end
		end
	end

	initial
	begin
		repeat (NUM_CMDS * (SCAN_LEN + 8) + RESET_CYCLES) @(posedge scc_clk);
		$display("Watchdog expired with %0d frames still outstanding.", exp_groups.size());
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		arst_n      = 1'b0;
		cmd_valid   = 1'b0;
		cmd_op      = OP_SET_PHASE;
		cmd_group   = '0;
		cmd_setting = '0;
		saw_stall   = 1'b0;
		for (int i = 0; i < NUM_GROUPS; i++)
			model_settings[i] = '0;
		repeat (RESET_CYCLES) @(posedge scc_clk);
		@(negedge scc_clk);
		arst_n = 1'b1;
		check_bit("ready after reset", 1'b1, cmd_ready);
		check_bit("enable idle after reset", 1'b1, scan_enable == '0);
		check_bit("update idle after reset", 1'b1, scan_update == '0);

		for (int g = 0; g < NUM_GROUPS; g++)
			send_cmd(OP_SCAN, GROUP_W'(g), '0);

		for (int n = 0; n < N_RAND; n++)
		begin
			rng = xorshift(rng);
			send_cmd(OP_SET_PHASE, rng[GROUP_W-1:0], rng[12:8]);
			send_cmd(OP_SCAN, rng[GROUP_W-1:0], '0);
		end

		// Every group holds a nonzero setting when the clear arrives.
		for (int g = 0; g < NUM_GROUPS; g++)
			send_cmd(OP_SET_PHASE, GROUP_W'(g), SETTING_WIDTH'(g + 1));
		send_cmd(OP_CLEAR_ALL, '0, '0);
		for (int g = 0; g < NUM_GROUPS; g++)
			send_cmd(OP_SCAN, GROUP_W'(g), '0);
		while (exp_groups.size() != 0)
			@(negedge scc_clk);

		// Refill the settings so the burst frames differ per group.
		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			rng = xorshift(rng);
			send_cmd(OP_SET_PHASE, GROUP_W'(g), rng[20:16]);
		end
		saw_stall = 1'b0;
		for (int n = 0; n < N_BURST; n++)
		begin
			rng = xorshift(rng);
			send_cmd(OP_SCAN, rng[GROUP_W-1:0], '0);
		end
		check_bit("ready dropped during burst", 1'b1, saw_stall);
		while (exp_groups.size() != 0)
			@(negedge scc_clk);
		repeat (3) @(negedge scc_clk);
		check_bit("ready recovered", 1'b1, cmd_ready);

		$display("Errors: %0d, frames checked: %0d", errors, frames_done);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
